//--- hw/decode_issue_defines.svh
/* Decode and issue stage sizes
   Data, register address, offset widths and execution unit count */

`ifndef DECODE_ISSUE_DEFINES_SVH
`define DECODE_ISSUE_DEFINES_SVH

// Data path and PC width
`define XLEN 32

`define REG_ADDR_W 5

// Branch offset and load-store offset widths
`define PC_OFFSET_W 21
`define LS_OFFSET_W 12

// Branch, ALU and load-store
`define NUM_UNITS 3

`endif

//--- hw/decode_issue_pkg.sv
/* Decode and issue types
   Major opcodes, ALU logic operations, stage occupancy and unit indices */

`include "decode_issue_defines.svh"

package decode_issue_pkg;

    // Major opcodes in instruction bits [6:2]
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_XOR = 2'd1,
        ALU_OR  = 2'd2,
        ALU_AND = 2'd3
    } alu_logic_op_t;

    typedef enum logic {
        STAGE_EMPTY = 1'b0,
        STAGE_FULL  = 1'b1
    } stage_state_t;

    // Bit positions in the unit vectors
    typedef enum logic [$clog2(`NUM_UNITS)-1:0] {
        BRANCH_UNIT = 0,
        ALU_UNIT    = 1,
        LS_UNIT     = 2
    } unit_idx_t;

endpackage

//--- hw/issue_control.sv
/* Issue stage control
   Occupancy FSM, source hazard check, stall and per-unit issue */

`timescale 1ns/1ps
`include "decode_issue_defines.svh"

module issue_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  decode_valid,
    input  logic [`NUM_UNITS-1:0] unit_needed,
    input  logic                  uses_rs1,
    input  logic                  uses_rs2,
    input  logic                  rs1_pending,
    input  logic                  rs2_pending,
    input  logic [`NUM_UNITS-1:0] unit_ready,
    input  logic                  issue_hold,
    input  logic                  issue_flush,
    output logic                  stage_load,
    output logic                  stage_full,
    output logic                  decode_advance,
    output logic [`NUM_UNITS-1:0] issue_to,
    output logic                  instruction_issued
);
    import decode_issue_pkg::*;

    stage_state_t          state;
    logic                  rs1_hazard;
    logic                  rs2_hazard;
    logic [`NUM_UNITS-1:0] operands_ready;
    logic [`NUM_UNITS-1:0] issuable;
    logic                  can_issue;
    logic                  issue_valid;

    //////////////////////////////////////////////////////////////
    // Occupancy
    always_ff @(posedge clk) begin
        if (rst || issue_flush) begin
            state <= STAGE_EMPTY;
        end else if (stage_load) begin
            state <= decode_valid ? STAGE_FULL : STAGE_EMPTY;
        end
    end

    assign stage_full = (state == STAGE_FULL);

    //////////////////////////////////////////////////////////////
    // Hazards and issue
    assign rs1_hazard = rs1_pending & uses_rs1;
    assign rs2_hazard = rs2_pending & uses_rs2;

    // Load-store forwards store data, so only rs1 has to be free
    always_comb begin
        operands_ready = {`NUM_UNITS{~rs1_hazard & ~rs2_hazard}};
        operands_ready[LS_UNIT] = ~rs1_hazard;
    end

    assign issuable = unit_needed & unit_ready & operands_ready;

    // Every needed unit must take it, so JAL/JALR go out in one cycle
    assign can_issue = (|unit_needed) && ((issuable | ~unit_needed) == '1);

    assign stage_load = ~issue_hold & (~stage_full | can_issue);
    assign decode_advance = decode_valid & stage_load;

    assign issue_valid = stage_full & ~issue_hold & ~issue_flush & can_issue;
    assign issue_to = {`NUM_UNITS{issue_valid}} & unit_needed;
    assign instruction_issued = |issue_to;

endmodule

//--- hw/issue_stage_decode.sv
/* Issue stage register
   Classifies the decoded word and holds PC, unit needs and load-store fields */

`timescale 1ns/1ps
`include "decode_issue_defines.svh"

module issue_stage_decode (
    input  logic                    clk,
    input  logic                    stage_load,
    input  logic [`XLEN-1:0]        decode_pc,
    input  logic [31:0]             decode_instruction,
    output logic [`NUM_UNITS-1:0]   unit_needed,
    output logic                    uses_rs1,
    output logic                    uses_rs2,
    output logic [`XLEN-1:0]        issue_pc,
    output logic [2:0]              issue_fn3,
    output logic [`LS_OFFSET_W-1:0] ls_offset,
    output logic                    ls_load,
    output logic                    ls_store,
    output logic [2:0]              ls_fn3
);
    import decode_issue_pkg::*;

    opcode_t               opcode;
    logic [`NUM_UNITS-1:0] unit_needed_d;
    logic                  uses_rs1_d;
    logic                  uses_rs2_d;

    assign opcode = opcode_t'(decode_instruction[6:2]);

    //////////////////////////////////////////////////////////////
    // Unit selection
    always_comb begin
        unit_needed_d = '0;
        unit_needed_d[BRANCH_UNIT] = opcode inside {BRANCH, JAL, JALR};
        // Bit 25 set on ARITH is M extension, not handled here
        unit_needed_d[ALU_UNIT] = ((opcode == ARITH) && !decode_instruction[25])
            || (opcode inside {ARITH_IMM, AUIPC, LUI, JAL, JALR});
        unit_needed_d[LS_UNIT] = opcode inside {LOAD, STORE};
    end

    // Register file reads
    assign uses_rs1_d = !(opcode inside {LUI, AUIPC, JAL});
    assign uses_rs2_d = opcode inside {BRANCH, STORE, ARITH};

    always_ff @(posedge clk) begin
        if (stage_load) begin
            issue_pc    <= decode_pc;
            issue_fn3   <= decode_instruction[14:12];
            unit_needed <= unit_needed_d;
            uses_rs1    <= uses_rs1_d;
            uses_rs2    <= uses_rs2_d;
            ls_load     <= (opcode == LOAD);
            ls_store    <= (opcode == STORE);
            // Stores split the immediate around rd
            if (opcode == STORE) begin
                ls_offset <= {decode_instruction[31:25], decode_instruction[11:7]};
            end else begin
                ls_offset <= decode_instruction[31:20];
            end
        end
    end

    // Word width comes straight from fn3 without atomics
    assign ls_fn3 = issue_fn3;

endmodule

//--- hw/alu_operand_decode.sv
/* ALU operand and operation decode
   Registers ALU control and picks between register data, PC and immediates */

`timescale 1ns/1ps
`include "decode_issue_defines.svh"

module alu_operand_decode (
    input  logic                           clk,
    input  logic                           stage_load,
    input  logic [`XLEN-1:0]               decode_pc,
    input  logic [31:0]                    decode_instruction,
    input  logic [`XLEN-1:0]               rs1_data,
    input  logic [`XLEN-1:0]               rs2_data,
    output logic [`XLEN:0]                 alu_in1,
    output logic [`XLEN:0]                 alu_in2,
    output decode_issue_pkg::alu_logic_op_t alu_logic_op,
    output logic                           alu_subtract,
    output logic                           alu_arith,
    output logic                           alu_lshift,
    output logic                           alu_shifter_path,
    output logic                           alu_slt_path,
    output logic [`REG_ADDR_W-1:0]         alu_shift_amount
);
    import decode_issue_pkg::*;

    opcode_t                 opcode;
    logic [2:0]              fn3;
    logic                    upper_or_jump;
    logic                    sub_op;
    logic [`XLEN-1:0]        imm_d;
    alu_logic_op_t           logic_op_d;
    logic [`XLEN-1:0]        pc_or_zero_r;
    logic [`XLEN-1:0]        imm_r;
    logic                    rs1_from_reg;
    logic                    rs2_from_reg;
    logic                    sign_ext_r;
    logic                    arith_bit_r;
    logic                    shamt_from_reg;
    logic [`REG_ADDR_W-1:0]  shamt_imm_r;
    logic [`XLEN-1:0]        op1;
    logic [`XLEN-1:0]        op2;

    assign opcode = opcode_t'(decode_instruction[6:2]);
    assign fn3 = decode_instruction[14:12];

    // LUI, AUIPC, JAL and JALR all go through the adder
    assign upper_or_jump = opcode inside {LUI, AUIPC, JAL, JALR};
    assign sub_op = (opcode == ARITH) && (fn3 == 3'b000) && decode_instruction[30];

    always_comb begin
        if (opcode inside {LUI, AUIPC}) begin
            imm_d = {decode_instruction[31:12], 12'b0};
        end else if (opcode inside {JAL, JALR}) begin
            imm_d = `XLEN'(4);
        end else begin
            imm_d = `XLEN'(signed'(decode_instruction[31:20]));
        end
    end

    always_comb begin
        case (fn3)
            3'b100:  logic_op_d = ALU_XOR;
            3'b110:  logic_op_d = ALU_OR;
            3'b111:  logic_op_d = ALU_AND;
            default: logic_op_d = ALU_ADD;
        endcase
        if (upper_or_jump) begin
            logic_op_d = ALU_ADD;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_load) begin
            pc_or_zero_r     <= (opcode inside {AUIPC, JAL, JALR}) ? decode_pc : '0;
            imm_r            <= imm_d;
            rs1_from_reg     <= !upper_or_jump;
            rs2_from_reg     <= !(upper_or_jump || (opcode == ARITH_IMM));
            alu_logic_op     <= logic_op_d;
            alu_subtract     <= !upper_or_jump && ((fn3 inside {3'b010, 3'b011}) || sub_op);
            alu_lshift       <= !fn3[2];
            alu_shifter_path <= !upper_or_jump && (fn3 inside {3'b001, 3'b101});
            alu_slt_path     <= !upper_or_jump && (fn3 inside {3'b010, 3'b011});
            sign_ext_r       <= (fn3 != 3'b011);
            arith_bit_r      <= decode_instruction[30];
            shamt_from_reg   <= (opcode == ARITH);
            shamt_imm_r      <= decode_instruction[24:20];
        end
    end

    //////////////////////////////////////////////////////////////
    // Operand select
    assign op1 = rs1_from_reg ? rs1_data : pc_or_zero_r;
    assign op2 = rs2_from_reg ? rs2_data : imm_r;

    // Extra top bit makes SLT and SLTU one compare
    assign alu_in1 = {op1[`XLEN-1] & sign_ext_r, op1};
    assign alu_in2 = {op2[`XLEN-1] & sign_ext_r, op2};

    assign alu_arith = op1[`XLEN-1] & arith_bit_r;
    assign alu_shift_amount = shamt_from_reg ? rs2_data[`REG_ADDR_W-1:0] : shamt_imm_r;

endmodule

//--- hw/branch_operand_decode.sv
/* Branch operand decode
   Registers the branch offset, jump kind, signedness and call/return hints */

`timescale 1ns/1ps
`include "decode_issue_defines.svh"

module branch_operand_decode (
    input  logic                    clk,
    input  logic                    stage_load,
    input  logic [31:0]             decode_instruction,
    output logic [`PC_OFFSET_W-1:0] pc_offset,
    output logic                    br_jal,
    output logic                    br_jalr,
    output logic                    br_use_signed,
    output logic                    br_is_call,
    output logic                    br_is_return
);
    import decode_issue_pkg::*;

    opcode_t                 opcode;
    logic [`REG_ADDR_W-1:0]  rs1_addr;
    logic [`REG_ADDR_W-1:0]  rd_addr;
    logic                    rs1_link;
    logic                    rd_link;
    logic [19:0]             jal_imm;
    logic [11:0]             br_imm;
    logic [`PC_OFFSET_W-1:0] pc_offset_d;

    assign opcode = opcode_t'(decode_instruction[6:2]);
    assign rs1_addr = decode_instruction[19:15];
    assign rd_addr = decode_instruction[11:7];

    // x1 and x5 are the link registers for the return stack
    assign rs1_link = rs1_addr inside {5'd1, 5'd5};
    assign rd_link = rd_addr inside {5'd1, 5'd5};

    assign jal_imm = {decode_instruction[31], decode_instruction[19:12],
                      decode_instruction[20], decode_instruction[30:21]};
    assign br_imm = {decode_instruction[31], decode_instruction[7],
                     decode_instruction[30:25], decode_instruction[11:8]};

    always_comb begin
        if (opcode == JALR) begin
            pc_offset_d = `PC_OFFSET_W'(signed'(decode_instruction[31:20]));
        end else if (opcode == JAL) begin
            pc_offset_d = `PC_OFFSET_W'(signed'({jal_imm, 1'b0}));
        end else begin
            pc_offset_d = `PC_OFFSET_W'(signed'({br_imm, 1'b0}));
        end
    end

    always_ff @(posedge clk) begin
        if (stage_load) begin
            pc_offset     <= pc_offset_d;
            br_jal        <= (opcode == JAL);
            br_jalr       <= (opcode == JALR);
            br_use_signed <= !(decode_instruction[14:12] inside {3'b110, 3'b111});
            br_is_call    <= (opcode inside {JAL, JALR}) && rd_link;
            br_is_return  <= (opcode == JALR) && rs1_link && (!rd_link || (rs1_addr != rd_addr));
        end
    end

endmodule

//--- hw/decode_issue.sv
/* Decode and issue stage top
   Connects issue control, the stage register and the unit operand decoders */

`timescale 1ns/1ps
`include "decode_issue_defines.svh"

module decode_issue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    decode_valid,
    input  logic [`XLEN-1:0]        decode_pc,
    input  logic [31:0]             decode_instruction,
    output logic                    decode_advance,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  logic                    rs1_pending,
    input  logic                    rs2_pending,
    input  logic [`NUM_UNITS-1:0]   unit_ready,
    input  logic                    issue_hold,
    input  logic                    issue_flush,
    output logic [`NUM_UNITS-1:0]   issue_to,
    output logic                    instruction_issued,
    output logic [`XLEN-1:0]        issue_pc,
    output logic                    issue_pc_valid,
    output logic [`XLEN:0]          alu_in1,
    output logic [`XLEN:0]          alu_in2,
    output logic [1:0]              alu_logic_op,
    output logic                    alu_subtract,
    output logic                    alu_arith,
    output logic                    alu_lshift,
    output logic                    alu_shifter_path,
    output logic                    alu_slt_path,
    output logic [`REG_ADDR_W-1:0]  alu_shift_amount,
    output logic [`PC_OFFSET_W-1:0] pc_offset,
    output logic [2:0]              br_fn3,
    output logic                    br_jal,
    output logic                    br_jalr,
    output logic                    br_use_signed,
    output logic                    br_is_call,
    output logic                    br_is_return,
    output logic [`LS_OFFSET_W-1:0] ls_offset,
    output logic                    ls_load,
    output logic                    ls_store,
    output logic [2:0]              ls_fn3
);

    logic                  stage_load;
    logic [`NUM_UNITS-1:0] unit_needed;
    logic                  uses_rs1;
    logic                  uses_rs2;

    issue_control issue_control_i (
        .clk, .rst, .decode_valid, .unit_needed, .uses_rs1, .uses_rs2,
        .rs1_pending, .rs2_pending, .unit_ready, .issue_hold, .issue_flush,
        .stage_load, .stage_full(issue_pc_valid), .decode_advance,
        .issue_to, .instruction_issued
    );

    issue_stage_decode issue_stage_decode_i (
        .clk, .stage_load, .decode_pc, .decode_instruction,
        .unit_needed, .uses_rs1, .uses_rs2, .issue_pc, .issue_fn3(br_fn3),
        .ls_offset, .ls_load, .ls_store, .ls_fn3
    );

    alu_operand_decode alu_operand_decode_i (
        .clk, .stage_load, .decode_pc, .decode_instruction, .rs1_data, .rs2_data,
        .alu_in1, .alu_in2, .alu_logic_op, .alu_subtract, .alu_arith, .alu_lshift,
        .alu_shifter_path, .alu_slt_path, .alu_shift_amount
    );

    branch_operand_decode branch_operand_decode_i (
        .clk, .stage_load, .decode_instruction, .pc_offset,
        .br_jal, .br_jalr, .br_use_signed, .br_is_call, .br_is_return
    );

endmodule

//--- tb/decode_issue_assert.sv
/* Issue handshake assertions
   Bound into the decode and issue top level */

`timescale 1ns/1ps
`include "decode_issue_defines.svh"

module decode_issue_assert (
    input logic                  clk,
    input logic                  rst,
    input logic                  decode_valid,
    input logic                  decode_advance,
    input logic [`NUM_UNITS-1:0] unit_ready,
    input logic [`NUM_UNITS-1:0] issue_to,
    input logic                  issue_hold,
    input logic                  issue_flush
);

    // Never issue to a unit that is busy
    assert property (@(posedge clk) disable iff (rst) (issue_to & ~unit_ready) == '0)
        else $error("issue_to is high for a unit whose unit_ready is low");

    assert property (@(posedge clk) disable iff (rst)
        (issue_hold || issue_flush) |-> (issue_to == '0))
        else $error("issue_to is high during issue_hold or issue_flush");

    // Advance only takes a valid word
    assert property (@(posedge clk) disable iff (rst) decode_advance |-> decode_valid)
        else $error("decode_advance is high without decode_valid");

endmodule

bind decode_issue decode_issue_assert decode_issue_assert_i (
    .clk(clk),
    .rst(rst),
    .decode_valid(decode_valid),
    .decode_advance(decode_advance),
    .unit_ready(unit_ready),
    .issue_to(issue_to),
    .issue_hold(issue_hold),
    .issue_flush(issue_flush)
);

//--- tb/decode_issue_tb.sv
/* Decode and issue stage testbench
   Replays a per-cycle trace of inputs and checks the expected outputs */

`timescale 1ns/1ps
`include "decode_issue_defines.svh"

module decode_issue_tb;
    import decode_issue_pkg::*;

    logic                    clk;
    logic                    rst;
    logic                    decode_valid;
    logic [`XLEN-1:0]        decode_pc;
    logic [31:0]             decode_instruction;
    logic                    decode_advance;
    logic [`XLEN-1:0]        rs1_data;
    logic [`XLEN-1:0]        rs2_data;
    logic                    rs1_pending;
    logic                    rs2_pending;
    logic [`NUM_UNITS-1:0]   unit_ready;
    logic                    issue_hold;
    logic                    issue_flush;
    logic [`NUM_UNITS-1:0]   issue_to;
    logic                    instruction_issued;
    logic [`XLEN-1:0]        issue_pc;
    logic                    issue_pc_valid;
    logic [`XLEN:0]          alu_in1;
    logic [`XLEN:0]          alu_in2;
    logic [1:0]              alu_logic_op;
    logic                    alu_subtract;
    logic                    alu_arith;
    logic                    alu_lshift;
    logic                    alu_shifter_path;
    logic                    alu_slt_path;
    logic [`REG_ADDR_W-1:0]  alu_shift_amount;
    logic [`PC_OFFSET_W-1:0] pc_offset;
    logic [2:0]              br_fn3;
    logic                    br_jal;
    logic                    br_jalr;
    logic                    br_use_signed;
    logic                    br_is_call;
    logic                    br_is_return;
    logic [`LS_OFFSET_W-1:0] ls_offset;
    logic                    ls_load;
    logic                    ls_store;
    logic [2:0]              ls_fn3;

    string       trace_q[$];
    string       line;
    string       exp_adv, exp_to, exp_iss, exp_in1, exp_in2;
    string       exp_sub, exp_off, exp_call, exp_ret, exp_ls;
    int          fd;
    int          fields;
    int          line_no;
    int unsigned watchdog_ns;
    logic        model_full;
    logic [`XLEN-1:0] held_pc;
    logic [31:0] held_word;

    decode_issue decode_issue_i (.*);

    always #2 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Mismatch at %0t ns: line %0d %s expected %h, got %h",
                                $time, line_no, name, expected, actual));
        end
    endtask

    // An x token in the trace leaves that output unchecked
    task automatic check_field(input string name, input string token, input logic [63:0] actual);
        logic [63:0] expected;
        int          n;
        if (token != "x") begin
            n = $sscanf(token, "%h", expected);
            if (n != 1) begin
                abort_run($sformatf("Unreadable value %s for %s on trace line %0d",
                                    token, name, line_no));
            end else begin
                compare_value(name, expected, actual);
            end
        end
    endtask

    // Only the bitwise fn3 codes leave the adder
    function automatic alu_logic_op_t expected_logic_op(input logic [2:0] fn3);
        case (fn3)
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    // Registered fields of the word held in the issue stage, per RV32I
    task automatic verify_stage_fields();
        opcode_t    opc;
        logic [2:0] fn3;
        logic [4:0] shamt;
        opc = opcode_t'(held_word[6:2]);
        fn3 = held_word[14:12];
        shamt = (opc == ARITH) ? rs2_data[4:0] : held_word[24:20];
        compare_value("issue_pc", 64'(held_pc), 64'(issue_pc));
        compare_value("br_fn3", 64'(fn3), 64'(br_fn3));
        compare_value("ls_fn3", 64'(fn3), 64'(ls_fn3));
        compare_value("br_jal", 64'(opc == JAL), 64'(br_jal));
        compare_value("br_jalr", 64'(opc == JALR), 64'(br_jalr));
        compare_value("ls_load", 64'(opc == LOAD), 64'(ls_load));
        compare_value("ls_store", 64'(opc == STORE), 64'(ls_store));
        // BLTU and BGEU compare unsigned
        if (opc == BRANCH) begin
            compare_value("br_use_signed", 64'(!fn3[1]), 64'(br_use_signed));
        end
        if (opc inside {ARITH_IMM, ARITH}) begin
            compare_value("alu_logic_op", 64'(expected_logic_op(fn3)), 64'(alu_logic_op));
            compare_value("alu_shifter_path", 64'(fn3[1:0] == 2'b01), 64'(alu_shifter_path));
            compare_value("alu_slt_path", 64'(fn3[2:1] == 2'b01), 64'(alu_slt_path));
            compare_value("alu_lshift", 64'(!fn3[2]), 64'(alu_lshift));
            compare_value("alu_arith", 64'(held_word[30] & rs1_data[31]), 64'(alu_arith));
            compare_value("alu_shift_amount", 64'(shamt), 64'(alu_shift_amount));
        end else if (opc inside {LUI, AUIPC, JAL, JALR}) begin
            // Upper immediates and link addresses go through the adder
            compare_value("alu_logic_op", 64'(ALU_ADD), 64'(alu_logic_op));
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Watchdog sized from the trace length
    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        abort_run("Timeout: the trace replay did not finish in time");
    end

    //////////////////////////////////////////////////////////////
    // Reset and trace replay
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        decode_valid = 1'b0;
        decode_pc = '0;
        decode_instruction = '0;
        rs1_data = '0;
        rs2_data = '0;
        rs1_pending = 1'b0;
        rs2_pending = 1'b0;
        unit_ready = '1;
        issue_hold = 1'b0;
        issue_flush = 1'b0;
        watchdog_ns = 0;
        model_full = 1'b0;
        held_pc = '0;
        held_word = '0;

        fd = $fopen("tb/decode_issue_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file tb/decode_issue_trace.txt");
        end
        // Skip comment and blank lines
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 2 && line.getc(0) != "#") begin
                trace_q.push_back(line);
            end
        end
        $fclose(fd);
        if (trace_q.size() == 0) begin
            abort_run("The trace file holds no cycles");
        end
        watchdog_ns = 4 * trace_q.size() + 200;

        repeat (5) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < trace_q.size(); i++) begin
            line_no = i + 1;
            fields = $sscanf(trace_q[i],
                "%h %h %h %h %h %h %h %h %h %h %s %s %s %s %s %s %s %s %s %s",
                decode_valid, decode_pc, decode_instruction, rs1_data, rs2_data,
                rs1_pending, rs2_pending, unit_ready, issue_hold, issue_flush,
                exp_adv, exp_to, exp_iss, exp_in1, exp_in2,
                exp_sub, exp_off, exp_call, exp_ret, exp_ls);
            if (fields != 20) begin
                abort_run($sformatf("Trace line %0d has %0d fields instead of 20",
                                    line_no, fields));
            end
            // Sample one ns before the rising edge, after the inputs settle
            #1;
            check_field("decode_advance", exp_adv, 64'(decode_advance));
            check_field("issue_to", exp_to, 64'(issue_to));
            check_field("instruction_issued", exp_iss, 64'(instruction_issued));
            check_field("alu_in1", exp_in1, 64'(alu_in1));
            check_field("alu_in2", exp_in2, 64'(alu_in2));
            check_field("alu_subtract", exp_sub, 64'(alu_subtract));
            check_field("pc_offset", exp_off, 64'(pc_offset));
            check_field("br_is_call", exp_call, 64'(br_is_call));
            check_field("br_is_return", exp_ret, 64'(br_is_return));
            check_field("ls_offset", exp_ls, 64'(ls_offset));
            compare_value("issue_pc_valid", 64'(model_full), 64'(issue_pc_valid));
            if (model_full) begin
                verify_stage_fields();
            end
            // Occupancy after the coming rising edge
            if (issue_flush) begin
                model_full = 1'b0;
            end else if (decode_advance) begin
                model_full = 1'b1;
                held_pc = decode_pc;
                held_word = decode_instruction;
            end else if (instruction_issued) begin
                model_full = 1'b0;
            end
            @(negedge clk);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- tb/decode_issue_trace.txt
# valid pc instr rs1_data rs2_data rs1_pend rs2_pend unit_ready hold flush, then expected:
# advance issue_to issued alu_in1 alu_in2 alu_subtract pc_offset call return ls_offset (x = skip)
0 00000000 00000000 00000000 00000000 0 0 7 0 0  0 0 0 x x x x x x x
1 00000100 ffd10093 00000000 00000000 0 0 7 0 0  1 0 0 x x x x x x x
1 00000104 123451b7 00000010 00000000 0 0 7 0 0  1 2 1 000000010 1fffffffd 0 x x x x
1 00000108 80000217 00000000 00000000 0 0 7 0 0  1 2 1 000000000 012345000 0 x x x x
1 0000010c 407302b3 00000000 00000000 0 0 7 0 0  1 2 1 000000108 180000000 0 x x x x
1 00000110 fe208ce3 00000020 80000001 0 0 7 0 0  1 2 1 000000020 180000001 1 x x x x
1 00000114 010000ef 00000000 00000000 0 0 7 0 0  1 1 1 x x x 1ffff8 0 0 x
1 00000118 ffc4a403 00000000 00000000 0 0 7 0 0  1 3 1 000000114 000000004 0 000010 1 0 x
1 0000011c 00a5aa23 00000000 00000000 0 0 7 0 0  1 4 1 x x x x x x ffc
1 00000120 00e68633 00000000 00000000 0 1 7 0 0  1 4 1 x x x x x x 014
1 00000124 00008067 00000000 00000000 0 1 7 0 0  0 0 0 x x x x x x x
1 00000124 00008067 00000000 00000000 0 1 7 0 0  0 0 0 x x x x x x x
1 00000124 00008067 00000000 00000000 0 0 7 0 0  1 2 1 x x x x x x x
1 00000128 00510093 00000000 00000000 0 0 5 0 0  0 0 0 x x x 000000 0 1 x
1 00000128 00510093 00000000 00000000 0 0 7 1 0  0 0 0 x x x 000000 0 1 x
1 00000128 00510093 00000000 00000000 0 0 7 0 0  1 3 1 x x x 000000 0 1 x
1 0000012c 123451b7 00000000 00000000 1 0 7 0 0  0 0 0 x x x x x x x
1 0000012c 123451b7 00000000 00000000 1 0 7 0 1  0 0 0 x x x x x x x
1 0000012c 123451b7 00000000 00000000 0 0 7 0 0  1 0 0 x x x x x x x
0 00000000 00000000 00000000 00000000 0 0 7 0 0  0 2 1 000000000 012345000 0 x x x x
0 00000000 00000000 00000000 00000000 0 0 7 0 0  0 0 0 x x x x x x x

//--- src.f
+incdir+hw
hw/decode_issue_pkg.sv
hw/issue_control.sv
hw/issue_stage_decode.sv
hw/alu_operand_decode.sv
hw/branch_operand_decode.sv
hw/decode_issue.sv
tb/decode_issue_assert.sv
tb/decode_issue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode and issue testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module decode_issue_tb \
    -Mdir build/obj_dir -o decode_issue_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./build/obj_dir/decode_issue_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
